// File: logic/core_cfg_pkg.sv
/* Port-level types of the core: instruction-memory request and retire trace record */
`default_nettype none

package core_cfg_pkg;

	//////////////////////////////
	// Instruction memory port
	//////////////////////////////

	// Request to the synchronous program ROM
	// Data for addr comes back one cycle later
	typedef struct packed {
		logic        en;
		logic [31:0] addr;
	} imem_req_t;

	//////////////////////////////
	// Retire trace
	//////////////////////////////

	// One register write, reported the cycle after execute
	// valid stays low for branches, x0 writes and illegal words
	typedef struct packed {
		logic        valid;
		logic [4:0]  rd;
		logic [31:0] data;
		// Address of the instruction that wrote rd
		logic [31:0] pc;
	} retire_t;

endpackage : core_cfg_pkg

`default_nettype wire

// File: logic/isa_pkg.sv
/* RV32I subset description: opcode, ALU operation and sequencer state enums,
   and the decoded instruction struct */
`default_nettype none

package isa_pkg;

	//////////////////////////////
	// Major opcodes
	//////////////////////////////

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	// ALU operations, PASS_B forwards the second operand (LUI)
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		PASS_B
	} alu_op_e;

	// One instruction walks through all three states
	typedef enum logic [1:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC
	} seq_state_e;

	//////////////////////////////
	// Decoded instruction
	//////////////////////////////

	typedef struct packed {
		alu_op_e     alu_op;
		// Second operand is imm instead of rs2
		logic        use_imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		logic        is_branch;
		// BNE when set, BEQ otherwise
		logic        branch_ne;
		logic        is_jal;
		logic        reg_write;
		logic        illegal;
	} decoded_t;

endpackage : isa_pkg

`default_nettype wire

// File: logic/instr_fetch.sv
/* Instruction fetch: program counter, ROM request and the captured current
   instruction with its address */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch import core_cfg_pkg::*; #(
	parameter int          XLEN      = 32,
	parameter logic [31:0] BOOT_ADDR = 32'h0
) (
	input  wire logic            clk_i,
	input  wire logic            rstn_i,
	input  wire logic            next_instr_i,
	input  wire logic            jmp_i,
	input  wire logic [XLEN-1:0] jmp_addr_i,
	input  wire logic [XLEN-1:0] imem_rdata_i,
	output imem_req_t            imem_o,
	output logic      [XLEN-1:0] cinstr_o,
	output logic      [XLEN-1:0] pc_o
);

	logic [XLEN-1:0] pc_q;
	// Address whose ROM data is on imem_rdata_i this cycle
	logic [XLEN-1:0] rd_addr_q;

	// ROM is always enabled, the address follows the PC
	assign imem_o.en   = 1'b1;
	assign imem_o.addr = pc_q;

	// PC only moves when the sequencer finishes an instruction
	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			pc_q <= BOOT_ADDR;
		end else if (next_instr_i) begin
			if (jmp_i) begin
				pc_q <= jmp_addr_i;
			end else begin
				pc_q <= pc_q + XLEN'(4);
			end
		end
	end

	// Capture ROM data every cycle and keep its address alongside
	always_ff @(posedge clk_i) begin
		rd_addr_q <= pc_q;
		cinstr_o  <= imem_rdata_i;
		pc_o      <= rd_addr_q;
	end

	// Every PC update, sequential or jump, lands on a word boundary
	a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
		next_instr_i |=> (pc_q[1:0] == 2'b00));

endmodule : instr_fetch

`default_nettype wire

// File: logic/instr_decode.sv
/* Sequencer FSM and instruction decoder: fields, immediates, ALU op mapping */
`timescale 1ns/1ps
`default_nettype none

module instr_decode import isa_pkg::*; #(
	parameter int XLEN = 32
) (
	input  wire logic            clk_i,
	input  wire logic            rstn_i,
	input  wire logic [XLEN-1:0] cinstr_i,
	output decoded_t             dec_o,
	output logic                 exec_en_o,
	output logic                 next_instr_o
);

	seq_state_e state_q;
	decoded_t   dec_d;
	logic [2:0] funct3;
	logic [6:0] funct7;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			state_q <= S_FETCH;
		end else begin
			case (state_q)
				S_FETCH:  state_q <= S_DECODE;
				S_DECODE: state_q <= S_EXEC;
				default:  state_q <= S_FETCH;
			endcase
		end
	end

	// Execute lasts one cycle and steps the fetch unit on its closing edge
	assign exec_en_o    = (state_q == S_EXEC);
	assign next_instr_o = (state_q == S_EXEC);

	//////////////////////////////
	// Field decode
	//////////////////////////////

	assign funct3 = cinstr_i[14:12];
	assign funct7 = cinstr_i[31:25];

	always_comb begin
		dec_d     = '0;
		dec_d.rd  = cinstr_i[11:7];
		dec_d.rs1 = cinstr_i[19:15];
		dec_d.rs2 = cinstr_i[24:20];
		case (cinstr_i[6:0])
			OP_LUI: begin
				// U-type, upper 20 bits
				dec_d.imm       = {cinstr_i[31:12], 12'b0};
				dec_d.alu_op    = PASS_B;
				dec_d.use_imm   = 1'b1;
				dec_d.reg_write = 1'b1;
			end
			OP_IMM: begin
				// I-type, only ADDI in this subset
				dec_d.imm       = {{20{cinstr_i[31]}}, cinstr_i[31:20]};
				dec_d.use_imm   = 1'b1;
				dec_d.alu_op    = ADD;
				dec_d.reg_write = (funct3 == 3'b000);
				dec_d.illegal   = (funct3 != 3'b000);
			end
			OP_REG: begin
				dec_d.reg_write = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: dec_d.alu_op = ADD;
					10'b0100000_000: dec_d.alu_op = SUB;
					10'b0000000_111: dec_d.alu_op = AND;
					10'b0000000_110: dec_d.alu_op = OR;
					10'b0000000_100: dec_d.alu_op = XOR;
					10'b0000000_010: dec_d.alu_op = SLT;
					default: begin
						dec_d.reg_write = 1'b0;
						dec_d.illegal   = 1'b1;
					end
				endcase
			end
			OP_BRANCH: begin
				// B-type offset, bit 0 always zero
				dec_d.imm = {{19{cinstr_i[31]}}, cinstr_i[31], cinstr_i[7],
					cinstr_i[30:25], cinstr_i[11:8], 1'b0};
				dec_d.is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
				dec_d.branch_ne = funct3[0];
				dec_d.illegal   = (funct3[2:1] != 2'b00);
			end
			OP_JAL: begin
				// J-type offset
				dec_d.imm = {{11{cinstr_i[31]}}, cinstr_i[31], cinstr_i[19:12],
					cinstr_i[20], cinstr_i[30:21], 1'b0};
				dec_d.is_jal    = 1'b1;
				dec_d.reg_write = 1'b1;
			end
			default: dec_d.illegal = 1'b1;
		endcase
	end

	assign dec_o = dec_d;

	// The strobe only ever closes a full fetch, decode, execute walk
	a_next_after_walk: assert property (@(posedge clk_i) disable iff (!rstn_i)
		next_instr_o |-> ($past(state_q) == S_DECODE) && ($past(state_q, 2) == S_FETCH));

endmodule : instr_decode

`default_nettype wire

// File: logic/exec_unit.sv
/* Execute stage: ALU, branch compare and next-PC target */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import isa_pkg::*; #(
	parameter int XLEN = 32
) (
	input  wire logic            exec_en_i,
	input  wire decoded_t        dec_i,
	input  wire logic [XLEN-1:0] pc_i,
	input  wire logic [XLEN-1:0] rs1_data_i,
	input  wire logic [XLEN-1:0] rs2_data_i,
	output logic      [XLEN-1:0] wb_data_o,
	output logic                 jmp_o,
	output logic      [XLEN-1:0] jmp_addr_o
);

	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_res;
	logic            rs_equal;
	logic            br_taken;

	//////////////////////////////
	// ALU
	//////////////////////////////

	// Immediate forms replace rs2
	assign op_b = dec_i.use_imm ? dec_i.imm : rs2_data_i;

	always_comb begin
		case (dec_i.alu_op)
			ADD:     alu_res = rs1_data_i + op_b;
			SUB:     alu_res = rs1_data_i - op_b;
			AND:     alu_res = rs1_data_i & op_b;
			OR:      alu_res = rs1_data_i | op_b;
			XOR:     alu_res = rs1_data_i ^ op_b;
			// Signed compare, result is 0 or 1
			SLT:     alu_res = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
			PASS_B:  alu_res = op_b;
			default: alu_res = '0;
		endcase
	end

	//////////////////////////////
	// Control flow
	//////////////////////////////

	// Branches always compare the two registers
	assign rs_equal = (rs1_data_i == rs2_data_i);
	assign br_taken = dec_i.is_branch && (dec_i.branch_ne ? !rs_equal : rs_equal);

	// Both BEQ/BNE and JAL are PC relative
	assign jmp_addr_o = pc_i + dec_i.imm;
	assign jmp_o      = exec_en_i && (br_taken || dec_i.is_jal);

	// JAL links the return address
	assign wb_data_o = dec_i.is_jal ? (pc_i + XLEN'(4)) : alu_res;

endmodule : exec_unit

`default_nettype wire

// File: logic/reg_file.sv
/* 32-entry register file with the x0 rule and the retire report */
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_cfg_pkg::*; import isa_pkg::*; #(
	parameter int XLEN = 32
) (
	input  wire logic            clk_i,
	input  wire logic            rstn_i,
	input  wire logic            exec_en_i,
	input  wire decoded_t        dec_i,
	input  wire logic [XLEN-1:0] pc_i,
	input  wire logic [XLEN-1:0] wb_data_i,
	output logic      [XLEN-1:0] rs1_data_o,
	output logic      [XLEN-1:0] rs2_data_o,
	output retire_t              retire_o
);

	logic [XLEN-1:0] regs_q [32];
	logic            wr_en;

	// Writes to x0 are dropped here and never reported
	assign wr_en = exec_en_i && dec_i.reg_write && (dec_i.rd != 5'd0);

	// Combinational reads straight from the array
	assign rs1_data_o = regs_q[dec_i.rs1];
	assign rs2_data_o = regs_q[dec_i.rs2];

	// x0 is cleared at reset and never written afterwards
	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			regs_q[0] <= '0;
		end else if (wr_en) begin
			regs_q[dec_i.rd] <= wb_data_i;
		end
	end

	// Retire record goes out one cycle after the write
	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			retire_o <= '0;
		end else begin
			retire_o.valid <= wr_en;
			retire_o.rd    <= dec_i.rd;
			retire_o.data  <= wb_data_i;
			retire_o.pc    <= pc_i;
		end
	end

	// x0 reads zero on either port
	a_x0_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
		((dec_i.rs1 != 5'd0) || (rs1_data_o == '0)) &&
		((dec_i.rs2 != 5'd0) || (rs2_data_o == '0)));

endmodule : reg_file

`default_nettype wire

// File: logic/core_top.sv
/* Core top level: fetch, decode, execute and register file */
`timescale 1ns/1ps
`default_nettype none

module core_top import core_cfg_pkg::*; import isa_pkg::*; #(
	parameter int          XLEN      = 32,
	parameter logic [31:0] BOOT_ADDR = 32'h0
) (
	input  wire logic            clk_i,
	input  wire logic            rstn_i,
	// Program ROM, data one cycle after the address
	input  wire logic [XLEN-1:0] imem_rdata_i,
	output imem_req_t            imem_o,
	// Register write trace
	output retire_t              retire_o,
	output logic                 illegal_o
);

	logic [XLEN-1:0] cinstr;
	logic [XLEN-1:0] pc_cur;
	logic            next_instr;
	logic            jmp;
	logic [XLEN-1:0] jmp_addr;
	decoded_t        dec;
	logic            exec_en;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] wb_data;

	instr_fetch #(
		.XLEN         (XLEN),
		.BOOT_ADDR    (BOOT_ADDR)
	) u_fetch (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.next_instr_i (next_instr),
		.jmp_i        (jmp),
		.jmp_addr_i   (jmp_addr),
		.imem_rdata_i (imem_rdata_i),
		.imem_o       (imem_o),
		.cinstr_o     (cinstr),
		.pc_o         (pc_cur)
	);

	instr_decode #(.XLEN(XLEN)) u_decode (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.cinstr_i     (cinstr),
		.dec_o        (dec),
		.exec_en_o    (exec_en),
		.next_instr_o (next_instr)
	);

	exec_unit #(.XLEN(XLEN)) u_exec (
		.exec_en_i    (exec_en),
		.dec_i        (dec),
		.pc_i         (pc_cur),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.wb_data_o    (wb_data),
		.jmp_o        (jmp),
		.jmp_addr_o   (jmp_addr)
	);

	reg_file #(.XLEN(XLEN)) u_regs (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.exec_en_i    (exec_en),
		.dec_i        (dec),
		.pc_i         (pc_cur),
		.wb_data_i    (wb_data),
		.rs1_data_o   (rs1_data),
		.rs2_data_o   (rs2_data),
		.retire_o     (retire_o)
	);

	// Unknown encodings are flagged only while they execute
	assign illegal_o = exec_en && dec.illegal;

endmodule : core_top

`default_nettype wire

// File: verification/core_tb.sv
/* Testbench for core_top: clock, reset, program ROM model, cases-file reader,
   retire checker and result reporting */
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_cfg_pkg::*; ();

	localparam int          XLEN           = 32;
	localparam logic [31:0] BOOT_ADDR      = 32'h0;
	localparam int          CLK_PERIOD     = 100;
	localparam int          ROM_WORDS      = 256;
	localparam int          CASE_WORDS     = 512;
	localparam int          RETIRE_TIMEOUT = 20;
	localparam int          QUIET_CYCLES   = 12;
	localparam int          RANDOM_TEST    = 5;
	localparam int          ILLEGAL_TEST   = 6;

	logic        clk_i = 1'b0;
	logic        rstn_i;
	logic [31:0] imem_rdata_i = '0;
	imem_req_t   imem;
	retire_t     retire;
	logic        illegal;

	logic [31:0] rom [ROM_WORDS];
	logic [31:0] cases_mem [CASE_WORDS];
	// Request seen on the previous falling edge
	logic [31:0] last_addr = '0;
	logic        last_en = 1'b0;

	int     prog_len;
	int     rec_count;
	int     checks;
	int     errors;
	int     illegal_cnt = 0;
	bit     timed_out;
	integer seed;

	core_top #(
		.XLEN         (XLEN),
		.BOOT_ADDR    (BOOT_ADDR)
	) UUT (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.imem_rdata_i (imem_rdata_i),
		.imem_o       (imem),
		.retire_o     (retire),
		.illegal_o    (illegal)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	//////////////////////////////
	// Program ROM and monitors
	//////////////////////////////

	// Synchronous ROM, one cycle from the sampled address to its data
	always @(negedge clk_i) begin
		if (last_en) begin
			imem_rdata_i <= rom[last_addr[9:2]];
		end
		last_addr <= imem.addr;
		last_en   <= imem.en;
	end

	// One count per execute cycle of an unknown word
	always @(negedge clk_i) begin
		if (rstn_i && illegal) begin
			illegal_cnt <= illegal_cnt + 1;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// First word of retire record r
	function automatic int record_base(int r);
		return 2 + prog_len + 4 * r;
	endfunction

	function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] upper);
		return {upper, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] sign_ext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Next retire, sampled mid-cycle
	task automatic wait_retire(output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < RETIRE_TIMEOUT) begin
			@(negedge clk_i);
			seen = retire.valid;
			n++;
		end
	endtask

	// Only the illegal test and later ones see the flag
	task automatic finish_test(input int tid, input int errs_before);
		check_value($sformatf("test %0d illegal pulse count", tid), 32'(illegal_cnt),
			(tid >= ILLEGAL_TEST) ? 32'd1 : 32'd0);
		$display("Test %0d finished with %0d error(s)", tid, errors - errs_before);
	endtask

	task automatic load_program();
		int i;
		// Unused words carry their index and a zero opcode, so they decode as illegal
		for (i = 0; i < ROM_WORDS; i++) begin
			rom[i] = {i[24:0], 7'b0000000};
		end
		$readmemh("verification/core_cases.txt", cases_mem);
		prog_len  = int'(cases_mem[0]);
		rec_count = int'(cases_mem[1]);
		if (prog_len <= 0 || prog_len > ROM_WORDS || rec_count <= 0 ||
			record_base(rec_count) > CASE_WORDS) begin
			errors++;
			$display("Cases file has an unusable program length %0d or record count %0d",
				prog_len, rec_count);
			prog_len  = 0;
			rec_count = 0;
		end
		for (i = 0; i < prog_len; i++) begin
			rom[i] = cases_mem[2 + i];
		end
	endtask

	// Test 5 slots become LUI, ADDI, ADDI with random operands
	task automatic place_random_addi();
		int          slot[$];
		int          r;
		int          w;
		logic [31:0] src;
		logic [11:0] imm;
		logic [19:0] upper;
		logic [4:0]  rd_a;
		logic [4:0]  rd_b;
		logic [31:0] lui_val;
		for (r = 0; r < rec_count; r++) begin
			if (int'(cases_mem[record_base(r)]) == RANDOM_TEST) begin
				slot.push_back(r);
			end
		end
		if (slot.size() != 3) begin
			errors++;
			$display("Cases file has %0d records for test %0d instead of 3",
				slot.size(), RANDOM_TEST);
		end else begin
			src   = $random(seed);
			imm   = 12'($random(seed));
			// Rounded upper part, the low 12 bits are added back sign extended
			upper = 20'((src + 32'h800) >> 12);
			rd_a  = 5'(cases_mem[record_base(slot[0]) + 1]);
			rd_b  = 5'(cases_mem[record_base(slot[2]) + 1]);
			w     = int'(cases_mem[record_base(slot[0]) + 3] >> 2);
			rom[w]     = lui_word(rd_a, upper);
			rom[w + 1] = addi_word(rd_a, rd_a, src[11:0]);
			rom[w + 2] = addi_word(rd_b, rd_a, imm);
			lui_val = {upper, 12'h000};
			cases_mem[record_base(slot[0]) + 2] = lui_val;
			cases_mem[record_base(slot[1]) + 2] = lui_val + sign_ext12(src[11:0]);
			cases_mem[record_base(slot[2]) + 2] = lui_val + sign_ext12(src[11:0]) +
				sign_ext12(imm);
			$display("Test %0d operands: source %h, immediate %h", RANDOM_TEST, src, imm);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int r;
		int tid;
		int cur_test;
		int errs_before;
		bit seen;

		seed      = 32'h78a1822a;
		rstn_i    = 1'b0;
		checks    = 0;
		errors    = 0;
		timed_out = 1'b0;
		load_program();
		place_random_addi();

		// Test 1, reset held for three cycles
		errs_before = errors;
		repeat (3) begin
			@(negedge clk_i);
			check_value("test 1 retire valid in reset", 32'(retire.valid), 32'd0);
		end
		rstn_i = 1'b1;
		check_value("test 1 first fetch address", imem.addr, BOOT_ADDR);
		check_value("test 1 fetch enable", 32'(imem.en), 32'd1);
		finish_test(1, errs_before);

		// Tests 2 to 6 walk the retire records in program order
		cur_test    = (rec_count > 0) ? int'(cases_mem[record_base(0)]) : 0;
		errs_before = errors;
		for (r = 0; r < rec_count && !timed_out; r++) begin
			tid = int'(cases_mem[record_base(r)]);
			if (tid != cur_test) begin
				finish_test(cur_test, errs_before);
				cur_test    = tid;
				errs_before = errors;
			end
			wait_retire(seen);
			if (!seen) begin
				timed_out = 1'b1;
				$display("Timeout at %0t ns: no retire seen for test %0d record %0d",
					$time, tid, r);
			end else begin
				check_value($sformatf("test %0d retire rd", tid), 32'(retire.rd),
					cases_mem[record_base(r) + 1]);
				check_value($sformatf("test %0d retire data", tid), retire.data,
					cases_mem[record_base(r) + 2]);
				check_value($sformatf("test %0d retire pc", tid), retire.pc,
					cases_mem[record_base(r) + 3]);
			end
		end

		if (!timed_out && rec_count > 0) begin
			// Parked in the JAL x0 loop, nothing may retire
			repeat (QUIET_CYCLES) begin
				@(negedge clk_i);
				check_value("retire valid after program end", 32'(retire.valid), 32'd0);
			end
			finish_test(cur_test, errs_before);
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule : core_tb

`default_nettype wire

// File: verilog.f
logic/core_cfg_pkg.sv
logic/isa_pkg.sv
logic/instr_fetch.sv
logic/instr_decode.sv
logic/exec_unit.sv
logic/reg_file.sv
logic/core_top.sv
verification/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/core_cases.txt
// Word 0 program length, word 1 record count, then the program words,
// then one retire record per line with columns test, rd, value, pc (all hex)
00000018 00000011
// Test 2: lui, addi, add, addi -1, sub, and, or, xor, slt negative, slt
123450B7 67800113 002081B3 FFF00213
404102B3 0021F333 0020E3B3 0041C433
002224B3 004126B3
// Test 3: beq taken, skipped addi, bne not taken, addi, jal, skipped addi
00210463 00100713 00211463 00200793
0080086F 00300713
// Test 4: addi to x0, then add x12 from x0 and x2
00500013 00200633
// Test 5: three slots that get random lui and addi words at run time
00000013 00000013 00000013
// Test 6: custom-0 word with rd x11, addi x17, then a jal x0 parking loop
0000058B 01100893 0000006F
// Expected retire records
00000002 00000001 12345000 00000000
00000002 00000002 00000678 00000004
00000002 00000003 12345678 00000008
00000002 00000004 FFFFFFFF 0000000C
00000002 00000005 00000679 00000010
00000002 00000006 00000678 00000014
00000002 00000007 12345678 00000018
00000002 00000008 EDCBA987 0000001C
00000002 00000009 00000001 00000020
00000002 0000000D 00000000 00000024
00000003 0000000F 00000002 00000034
00000003 00000010 0000003C 00000038
00000004 0000000C 00000678 00000044
00000005 0000000A 00000000 00000048
00000005 0000000A 00000000 0000004C
00000005 0000000B 00000000 00000050
00000006 00000011 00000011 00000058
